// ==== mem_sub_consts.svh ====
`ifndef MEM_SUB_CONSTS_SVH
`define MEM_SUB_CONSTS_SVH

//////////////////////////////
// Data path widths
//////////////////////////////
`define WORD_W      32
`define LINE_WORDS  8            // Words per cache line
`define LINE_NO     8            // Direct mapped sets

//////////////////////////////
// Address split
//////////////////////////////
// Byte offset takes the low two bits
`define OFFSET_W    3
`define INDEX_W     3
`define TAG_W       24

// Bits 31..30 of a peripheral address
`define PERIPH_TAG  2'b01

`endif

// ==== mem_sub_pkg.sv ====
`include "mem_sub_consts.svh"

package mem_sub_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [31:0] addr_t;

   // Full cache line, word 0 in the low bits
   typedef logic [`LINE_WORDS*`WORD_W-1:0] line_t;

   typedef logic [`TAG_W-1:0] tag_t;
   typedef logic [`INDEX_W-1:0] index_t;
   typedef logic [`OFFSET_W-1:0] offset_t;   // Word within a line

   // Controller sequencing
   typedef enum logic [2:0] {
      IDLE,
      PERIPH,       // Waiting for peripheral completion
      EVICT,        // Dirty victim into write buffer
      FILL_FIRST,   // Waiting for critical word
      FILL_REST,
      INSTALL
   } ctrl_state_e;

endpackage

// ==== data_cache.sv ====
`timescale 1ns/1ps
`include "mem_sub_consts.svh"

module data_cache import mem_sub_pkg::*; (
   input  logic  Clk,
   input  logic  rst_i,
   input  addr_t addr_i,
   input  word_t wdata_i,
   input  logic  wr_i,
   input  logic  install_i,
   input  line_t fill_line_i,
   output word_t rdata_o,
   output logic  hit_o,
   output logic  victim_dirty_o,
   output addr_t victim_addr_o,
   output line_t victim_line_o
);

   //////////////////////////////
   // State arrays
   //////////////////////////////
   logic [`LINE_NO-1:0] valid_q;
   logic [`LINE_NO-1:0] dirty_q;
   tag_t                tag_mem [`LINE_NO];
   line_t               data_mem [`LINE_NO];

   tag_t    req_tag;
   index_t  req_idx;
   offset_t req_off;
   line_t   cur_line;

   assign req_tag = addr_i[31 -: `TAG_W];
   assign req_idx = addr_i[`OFFSET_W+2 +: `INDEX_W];
   assign req_off = addr_i[2 +: `OFFSET_W];

   assign cur_line = data_mem[req_idx];

   //////////////////////////////
   // Lookup
   //////////////////////////////
   assign hit_o   = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
   assign rdata_o = cur_line[req_off*`WORD_W +: `WORD_W];

   // Victim is whatever sits in the indexed set
   assign victim_dirty_o = valid_q[req_idx] && dirty_q[req_idx];
   assign victim_addr_o  = {tag_mem[req_idx], req_idx, {(`OFFSET_W+2){1'b0}}};
   assign victim_line_o  = cur_line;

   //////////////////////////////
   // Valid and dirty bits
   //////////////////////////////
   always_ff @(posedge Clk) begin
      if (rst_i) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (install_i) begin
            valid_q[req_idx] <= 1'b1;
            dirty_q[req_idx] <= 1'b0;   // New line arrives clean
         end else if (wr_i) begin
            dirty_q[req_idx] <= 1'b1;
         end
      end
   end

   //////////////////////////////
   // Tags and line storage
   //////////////////////////////
   always_ff @(posedge Clk) begin
      if (install_i) begin
         tag_mem[req_idx]  <= req_tag;
         data_mem[req_idx] <= fill_line_i;
      end else if (wr_i) begin
         // Single word store into a resident line
         data_mem[req_idx][req_off*`WORD_W +: `WORD_W] <= wdata_i;
      end
   end

endmodule

// ==== linefill_buffer.sv ====
`timescale 1ns/1ps
`include "mem_sub_consts.svh"

module linefill_buffer import mem_sub_pkg::*; (
   input  logic  Clk,
   input  logic  rst_i,
   input  logic  start_i,
   input  addr_t addr_i,
   input  word_t mem_rdata_i,
   input  logic  mem_rvalid_i,
   output logic  mem_rd_start_o,
   output addr_t mem_rd_addr_o,
   output logic  first_o,
   output logic  done_o,
   output line_t line_o
);

   logic    active_q;
   offset_t cnt_q;      // Words received so far
   offset_t wr_off;
   addr_t   base_q;     // Critical word address
   line_t   line_q;
   logic    take;

   assign take = active_q && mem_rvalid_i;

   // Wrap order starts at the critical word and rolls over mod 8
   assign wr_off = base_q[2 +: `OFFSET_W] + cnt_q;

   assign first_o = take && (cnt_q == '0);
   assign done_o  = take && (cnt_q == offset_t'(`LINE_WORDS-1));

   assign mem_rd_addr_o = base_q;
   assign line_o        = line_q;

   //////////////////////////////
   // Read sequencing
   //////////////////////////////
   always_ff @(posedge Clk) begin
      if (rst_i) begin
         active_q       <= 1'b0;
         cnt_q          <= '0;
         mem_rd_start_o <= 1'b0;
      end else begin
         mem_rd_start_o <= start_i;   // One cycle start strobe
         if (start_i) begin
            active_q <= 1'b1;
            cnt_q    <= '0;
         end else if (take) begin
            cnt_q <= cnt_q + 1'b1;
            if (done_o) begin
               active_q <= 1'b0;
            end
         end
      end
   end

   // Address and line data
   always_ff @(posedge Clk) begin
      if (start_i) begin
         base_q <= {addr_i[31:2], 2'b00};
      end
      if (take) begin
         line_q[wr_off*`WORD_W +: `WORD_W] <= mem_rdata_i;
      end
   end

endmodule

// ==== line_write_buffer.sv ====
`timescale 1ns/1ps
`include "mem_sub_consts.svh"

module line_write_buffer import mem_sub_pkg::*; (
   input  logic  Clk,
   input  logic  rst_i,
   input  logic  load_i,
   input  addr_t addr_i,
   input  line_t line_i,
   input  logic  mem_wnext_i,
   output logic  busy_o,
   output addr_t buf_addr_o,
   output logic  mem_wr_start_o,
   output addr_t mem_wr_addr_o,
   output word_t mem_wdata_o
);

   offset_t cnt_q;     // Next word to leave
   addr_t   addr_q;
   line_t   line_q;

   assign buf_addr_o    = addr_q;
   assign mem_wr_addr_o = addr_q;
   assign mem_wdata_o   = line_q[cnt_q*`WORD_W +: `WORD_W];

   //////////////////////////////
   // Drain control
   //////////////////////////////
   always_ff @(posedge Clk) begin
      if (rst_i) begin
         busy_o         <= 1'b0;
         cnt_q          <= '0;
         mem_wr_start_o <= 1'b0;
      end else begin
         mem_wr_start_o <= load_i;
         if (load_i) begin
            busy_o <= 1'b1;
            cnt_q  <= '0;
         end else if (busy_o && mem_wnext_i) begin
            cnt_q <= cnt_q + 1'b1;
            // Free after the last accept
            if (cnt_q == offset_t'(`LINE_WORDS-1)) begin
               busy_o <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge Clk) begin
      if (load_i) begin
         addr_q <= addr_i;
         line_q <= line_i;
      end
   end

endmodule

// ==== mem_controller.sv ====
`timescale 1ns/1ps
`include "mem_sub_consts.svh"

module mem_controller import mem_sub_pkg::*; (
   input  logic  Clk,
   input  logic  rst_i,
   input  logic  cpu_en_i,
   input  logic  cpu_we_i,
   input  addr_t cpu_addr_i,
   input  logic  hit_i,
   input  logic  victim_dirty_i,
   input  addr_t victim_addr_i,
   input  logic  lfb_first_i,
   input  logic  lfb_done_i,
   input  logic  lwb_busy_i,
   input  addr_t lwb_addr_i,
   input  logic  per_done_i,
   output logic  cpu_stall_o,
   output logic  crit_sel_o,
   output logic  cache_wr_o,
   output logic  install_o,
   output logic  lwb_load_o,
   output logic  lfb_start_o,
   output logic  per_rd_o,
   output logic  per_wr_o
);

   localparam int LA_LSB = `OFFSET_W + 2;   // Lowest line address bit

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   logic        stall_c;
   logic        is_periph;
   logic        drain_hazard;
   logic        evict_c;

   assign is_periph = (cpu_addr_i[31:30] == `PERIPH_TAG);

   // Requested line still on its way out to memory
   assign drain_hazard = lwb_busy_i &&
                         (lwb_addr_i[31:LA_LSB] == cpu_addr_i[31:LA_LSB]);

   assign evict_c = victim_dirty_i &&
                    (victim_addr_i[31:LA_LSB] != cpu_addr_i[31:LA_LSB]);

   //////////////////////////////
   // Next state and strobes
   //////////////////////////////
   always_comb begin
      state_d     = state_q;
      stall_c     = 1'b1;
      cache_wr_o  = 1'b0;
      install_o   = 1'b0;
      lwb_load_o  = 1'b0;
      lfb_start_o = 1'b0;
      case (state_q)
         IDLE: begin
            if (!cpu_en_i) begin
               stall_c = 1'b0;
            end else if (is_periph) begin
               state_d = PERIPH;          // Uncached window
            end else if (hit_i) begin
               stall_c    = 1'b0;
               cache_wr_o = cpu_we_i;
            end else if (evict_c) begin
               // Back-pressure while a previous line drains
               if (!lwb_busy_i) begin
                  state_d = EVICT;
               end
            end else if (!drain_hazard) begin
               lfb_start_o = 1'b1;
               state_d     = FILL_FIRST;
            end
         end
         EVICT: begin
            lwb_load_o  = 1'b1;
            lfb_start_o = 1'b1;           // Fill runs beside the drain
            state_d     = FILL_FIRST;
         end
         FILL_FIRST: begin
            if (lfb_first_i) begin
               stall_c = cpu_we_i;        // Reads finish on the critical word
               state_d = FILL_REST;
            end
         end
         FILL_REST: begin
            if (lfb_done_i) begin
               state_d = INSTALL;
            end
         end
         INSTALL: begin
            install_o = 1'b1;
            state_d   = IDLE;             // Write miss retries as a hit
         end
         PERIPH: begin
            if (per_done_i) begin
               stall_c = 1'b0;
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   assign cpu_stall_o = cpu_en_i && stall_c;
   assign crit_sel_o  = (state_q == FILL_FIRST);

   //////////////////////////////
   // State and peripheral strobes
   //////////////////////////////
   always_ff @(posedge Clk) begin
      if (rst_i) begin
         state_q  <= IDLE;
         per_rd_o <= 1'b0;
         per_wr_o <= 1'b0;
      end else begin
         state_q  <= state_d;
         per_rd_o <= (state_q == IDLE) && (state_d == PERIPH) && !cpu_we_i;
         per_wr_o <= (state_q == IDLE) && (state_d == PERIPH) && cpu_we_i;
      end
   end

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem import mem_sub_pkg::*; (
   input  logic  Clk,
   input  logic  rst_i,
   // Processor data port
   input  logic  cpu_en_i,
   input  logic  cpu_we_i,
   input  addr_t cpu_addr_i,
   input  word_t cpu_wdata_i,
   output logic  cpu_stall_o,
   output word_t cpu_rdata_o,
   // External memory
   output logic  mem_rd_start_o,
   output addr_t mem_rd_addr_o,
   input  word_t mem_rdata_i,
   input  logic  mem_rvalid_i,
   output logic  mem_wr_start_o,
   output addr_t mem_wr_addr_o,
   output word_t mem_wdata_o,
   input  logic  mem_wnext_i,
   // Peripheral port
   output logic  per_rd_o,
   output logic  per_wr_o,
   output addr_t per_addr_o,
   output word_t per_wdata_o,
   input  word_t per_rdata_i,
   input  logic  per_done_i
);

   logic  hit, victim_dirty, cache_wr, install, crit_sel;
   logic  lfb_start, lfb_first, lfb_done, lwb_load, lwb_busy;
   addr_t victim_addr, lwb_addr, cache_addr;
   line_t victim_line, fill_line;
   word_t cache_rdata;

   assign per_addr_o  = cpu_addr_i;
   assign per_wdata_o = cpu_wdata_i;

   // Install targets the fill address, the CPU may have moved on
   assign cache_addr = install ? mem_rd_addr_o : cpu_addr_i;

   // Critical word first, then peripheral return, else cache
   assign cpu_rdata_o = crit_sel   ? mem_rdata_i :
                        per_done_i ? per_rdata_i : cache_rdata;

   mem_controller u_ctrl (
      .Clk(Clk), .rst_i(rst_i), .cpu_en_i(cpu_en_i), .cpu_we_i(cpu_we_i),
      .cpu_addr_i(cpu_addr_i), .hit_i(hit), .victim_dirty_i(victim_dirty),
      .victim_addr_i(victim_addr), .lfb_first_i(lfb_first), .lfb_done_i(lfb_done),
      .lwb_busy_i(lwb_busy), .lwb_addr_i(lwb_addr), .per_done_i(per_done_i),
      .cpu_stall_o(cpu_stall_o), .crit_sel_o(crit_sel), .cache_wr_o(cache_wr),
      .install_o(install), .lwb_load_o(lwb_load), .lfb_start_o(lfb_start),
      .per_rd_o(per_rd_o), .per_wr_o(per_wr_o));

   data_cache u_cache (
      .Clk(Clk), .rst_i(rst_i), .addr_i(cache_addr), .wdata_i(cpu_wdata_i),
      .wr_i(cache_wr), .install_i(install), .fill_line_i(fill_line),
      .rdata_o(cache_rdata), .hit_o(hit), .victim_dirty_o(victim_dirty),
      .victim_addr_o(victim_addr), .victim_line_o(victim_line));

   linefill_buffer u_lfb (
      .Clk(Clk), .rst_i(rst_i), .start_i(lfb_start), .addr_i(cpu_addr_i),
      .mem_rdata_i(mem_rdata_i), .mem_rvalid_i(mem_rvalid_i),
      .mem_rd_start_o(mem_rd_start_o), .mem_rd_addr_o(mem_rd_addr_o),
      .first_o(lfb_first), .done_o(lfb_done), .line_o(fill_line));

   line_write_buffer u_lwb (
      .Clk(Clk), .rst_i(rst_i), .load_i(lwb_load), .addr_i(victim_addr),
      .line_i(victim_line), .mem_wnext_i(mem_wnext_i), .busy_o(lwb_busy),
      .buf_addr_o(lwb_addr), .mem_wr_start_o(mem_wr_start_o),
      .mem_wr_addr_o(mem_wr_addr_o), .mem_wdata_o(mem_wdata_o));

endmodule

// ==== mem_checker.sv ====
`timescale 1ns/1ps
`include "mem_sub_consts.svh"

module mem_checker import mem_sub_pkg::*; (
   input  logic  Clk,
   input  logic  rst_i,
   input  logic  cpu_en_i,
   input  logic  cpu_we_i,
   input  addr_t cpu_addr_i,
   input  word_t cpu_wdata_i,
   input  logic  cpu_stall_o,
   input  word_t cpu_rdata_o,
   input  logic  mem_rd_start_o,
   input  addr_t mem_rd_addr_o,
   input  logic  mem_wr_start_o,
   input  addr_t mem_wr_addr_o,
   input  word_t mem_wdata_o,
   input  logic  mem_wnext_i,
   input  logic  per_rd_o,
   input  logic  per_wr_o,
   input  addr_t per_addr_o,
   input  word_t per_wdata_o,
   output int    errors_o
);

   word_t               shadow [1024];      // Architectural memory contents
   word_t               preg_shadow [16];
   logic [`LINE_NO-1:0] line_valid;
   logic [`LINE_NO-1:0] line_dirty;
   tag_t                line_tag [`LINE_NO];
   logic                drain_on;
   logic [9:0]          drain_base;
   int                  drain_cnt;
   int                  reset_cycles;
   index_t              idx;
   logic                is_periph;
   addr_t               exp_addr;

   function automatic word_t mem_init_value(input int unsigned i);
      return 32'hC0DE_0000 ^ (i * 32'h0001_0003);
   endfunction

   task automatic report_mismatch(input string what, input word_t got, input word_t exp);
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors_o++;
   endtask

   task automatic report_error(input string what);
      $display("error at %0t: %s", $time, what);
      errors_o++;
   endtask

   initial begin
      errors_o     = 0;
      drain_on     = 1'b0;
      reset_cycles = 0;
      line_valid   = '0;
      line_dirty   = '0;
      for (int i = 0; i < 1024; i++) begin
         shadow[i] = mem_init_value(i);
      end
      for (int i = 0; i < 16; i++) begin
         preg_shadow[i] = 32'hBEEF_0000 | i;
      end
   end

   ///////////////////////////////
   // Sampled on the rising edge
   ///////////////////////////////
   always @(posedge Clk) begin
      idx       = cpu_addr_i[7:5];
      is_periph = (cpu_addr_i[31:30] == `PERIPH_TAG);
      exp_addr  = {line_tag[idx], idx, 5'b0};   // Victim line address
      if (rst_i) begin
         reset_cycles++;
         if (reset_cycles > 1 && (cpu_stall_o || mem_rd_start_o || mem_wr_start_o ||
                                  per_rd_o || per_wr_o)) begin
            report_error("stall or strobe active during reset");
         end
      end else begin
         if (mem_rd_start_o) begin
            if (is_periph) begin
               report_error("line fill started for a peripheral address");
            end
            if (mem_rd_addr_o != {cpu_addr_i[31:2], 2'b00}) begin
               report_mismatch("fill address", mem_rd_addr_o, {cpu_addr_i[31:2], 2'b00});
            end
            if (line_valid[idx] && line_tag[idx] == cpu_addr_i[31:8]) begin
               report_error("line fill started for a resident line");
            end
            if (mem_wr_start_o != (line_valid[idx] && line_dirty[idx])) begin
               report_error("write-back start does not follow the victim dirty bit");
            end else if (mem_wr_start_o) begin
               if (mem_wr_addr_o != exp_addr) begin
                  report_mismatch("write-back address", mem_wr_addr_o, exp_addr);
               end
               drain_on   = 1'b1;
               drain_cnt  = 0;
               drain_base = exp_addr[11:2];
            end
            line_valid[idx] = 1'b1;        // Installed clean
            line_tag[idx]   = cpu_addr_i[31:8];
            line_dirty[idx] = 1'b0;
         end else if (mem_wr_start_o) begin
            report_error("write-back started without a line fill");
         end
         // Evicted words leave in ascending order
         if (mem_wnext_i && drain_on) begin
            if (mem_wdata_o != shadow[drain_base + 10'(drain_cnt)]) begin
               report_mismatch("write-back word", mem_wdata_o,
                               shadow[drain_base + 10'(drain_cnt)]);
            end
            drain_cnt++;
            if (drain_cnt == `LINE_WORDS) begin
               drain_on = 1'b0;
            end
         end
         if (per_rd_o || per_wr_o) begin
            if (!is_periph || per_addr_o != cpu_addr_i) begin
               report_error("peripheral strobe for an address outside the window");
            end
            if (per_wr_o != cpu_we_i) begin
               report_error("peripheral strobe of the wrong kind");
            end
            if (per_wr_o && per_wdata_o != cpu_wdata_i) begin
               report_mismatch("peripheral write data", per_wdata_o, cpu_wdata_i);
            end
         end
         if (cpu_en_i && !cpu_stall_o) begin
            if (is_periph) begin
               if (cpu_we_i) begin
                  preg_shadow[cpu_addr_i[5:2]] = cpu_wdata_i;
               end else if (cpu_rdata_o != preg_shadow[cpu_addr_i[5:2]]) begin
                  report_mismatch("peripheral read", cpu_rdata_o,
                                  preg_shadow[cpu_addr_i[5:2]]);
               end
            end else if (cpu_we_i) begin
               shadow[cpu_addr_i[11:2]] = cpu_wdata_i;
               line_dirty[idx]          = 1'b1;
            end else if (cpu_rdata_o != shadow[cpu_addr_i[11:2]]) begin
               report_mismatch("memory read", cpu_rdata_o, shadow[cpu_addr_i[11:2]]);
            end
         end
      end
   end

endmodule

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_sub_consts.svh"

module tb_mem_subsystem import mem_sub_pkg::*; ();

   localparam int N_ENTRIES = 40;
   localparam int LIMIT     = N_ENTRIES * 60 + 16;   // Timeout in cycles

   // Kind (1 = write), address, write data
   localparam logic [64:0] STIM [N_ENTRIES] = '{
      {1'b0, 32'h0000_0014, 32'h0},           // Cold miss on critical word 5
      {1'b0, 32'h0000_0000, 32'h0},
      {1'b1, 32'h0000_0008, 32'h1111_1111},   // Write hit
      {1'b0, 32'h0000_0008, 32'h0},
      {1'b0, 32'h0000_001C, 32'h0},
      {1'b1, 32'h0000_0030, 32'h2222_2222},   // Write miss allocates
      {1'b0, 32'h0000_0030, 32'h0},
      {1'b0, 32'h0000_0024, 32'h0},
      {1'b0, 32'h0000_0104, 32'h0},           // Dirty eviction of 0x000
      {1'b0, 32'h0000_0008, 32'h0},           // Refill while draining
      {1'b0, 32'h0000_0120, 32'h0},
      {1'b0, 32'h0000_0030, 32'h0},
      {1'b1, 32'h0000_0040, 32'h3333_3333},
      {1'b1, 32'h0000_005C, 32'h4444_4444},
      {1'b0, 32'h0000_0140, 32'h0},
      {1'b0, 32'h0000_015C, 32'h0},
      {1'b1, 32'h4000_0008, 32'h5555_5555},   // Peripheral window
      {1'b0, 32'h4000_0008, 32'h0},
      {1'b0, 32'h4000_003C, 32'h0},
      {1'b1, 32'h7FFF_FFF0, 32'h6666_6666},
      {1'b0, 32'h7FFF_FFF0, 32'h0},
      {1'b0, 32'h0000_005C, 32'h0},           // Clean eviction
      {1'b0, 32'h0000_0200, 32'h0},
      {1'b1, 32'h0000_03E0, 32'h7777_7777},
      {1'b0, 32'h0000_07E0, 32'h0},
      {1'b0, 32'h0000_03E0, 32'h0},
      {1'b1, 32'h0000_0FFC, 32'h8888_8888},
      {1'b0, 32'h0000_0FFC, 32'h0},
      {1'b0, 32'h0000_03E0, 32'h0},
      {1'b0, 32'h4000_0004, 32'h0},
      {1'b1, 32'h0000_0060, 32'h9999_9999},
      {1'b1, 32'h0000_0080, 32'hAAAA_AAAA},
      {1'b0, 32'h0000_0160, 32'h0},           // Dirty eviction of 0x060
      {1'b0, 32'h0000_0180, 32'h0},           // May stall on the busy write buffer
      {1'b0, 32'h0000_0060, 32'h0},
      {1'b0, 32'h0000_0080, 32'h0},
      {1'b1, 32'h4000_0010, 32'hBBBB_BBBB},
      {1'b0, 32'h4000_0010, 32'h0},
      {1'b0, 32'h0000_0FFC, 32'h0},
      {1'b0, 32'h0000_0008, 32'h0}
   };

   logic  Clk, rst_i, cpu_en_i, cpu_we_i, cpu_stall_o;
   addr_t cpu_addr_i, mem_rd_addr_o, mem_wr_addr_o, per_addr_o;
   word_t cpu_wdata_i, cpu_rdata_o, mem_rdata_i, mem_wdata_o, per_wdata_o, per_rdata_i;
   logic  mem_rd_start_o, mem_rvalid_i, mem_wr_start_o, mem_wnext_i;
   logic  per_rd_o, per_wr_o, per_done_i;
   word_t mem [1024];
   word_t preg [16];
   logic [9:0] rd_base, wr_base;
   logic [2:0] woff;
   logic [3:0] pidx;
   logic       pwr;
   logic       wr_busy;     // Write-back still arriving at the memory model
   int         errors, cycles;

   mem_subsystem u_mem_subsystem (.*);

   mem_checker u_checker (.*, .errors_o(errors));

   initial begin
      Clk = 1'b0;
      forever #50 Clk = ~Clk;
   end

   ///////////////////////////////
   // External memory model
   ///////////////////////////////
   initial begin
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
      forever begin
         @(posedge Clk);
         if (mem_rd_start_o) begin
            rd_base = mem_rd_addr_o[11:2];
            for (int k = 0; k < `LINE_WORDS; k++) begin
               repeat ($urandom % 4) @(negedge Clk);
               @(negedge Clk);
               woff         = rd_base[2:0] + 3'(k);   // Wraps inside the line
               mem_rdata_i  = mem[{rd_base[9:3], woff}];
               mem_rvalid_i = 1'b1;
               @(negedge Clk);
               mem_rvalid_i = 1'b0;
            end
         end
      end
   end

   initial begin
      mem_wnext_i = 1'b0;
      wr_busy     = 1'b0;
      forever begin
         @(posedge Clk);
         if (mem_wr_start_o) begin
            wr_busy = 1'b1;
            wr_base = mem_wr_addr_o[11:2];
            for (int j = 0; j < `LINE_WORDS; j++) begin
               repeat ($urandom % 4) @(negedge Clk);
               @(negedge Clk);
               mem[wr_base + 10'(j)] = mem_wdata_o;
               mem_wnext_i           = 1'b1;
               @(negedge Clk);
               mem_wnext_i = 1'b0;
            end
            wr_busy = 1'b0;
         end
      end
   end

   // Peripheral registers with random completion delay
   initial begin
      per_done_i  = 1'b0;
      per_rdata_i = '0;
      forever begin
         @(posedge Clk);
         if (per_rd_o || per_wr_o) begin
            pidx = per_addr_o[5:2];
            pwr  = per_wr_o;
            repeat ($urandom % 5) @(negedge Clk);
            @(negedge Clk);
            if (pwr) begin
               preg[pidx] = per_wdata_o;
            end
            per_rdata_i = preg[pidx];
            per_done_i  = 1'b1;
            @(negedge Clk);
            per_done_i = 1'b0;
         end
      end
   end

   always @(posedge Clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("timeout: run exceeded %0d cycles", LIMIT);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   ///////////////////////////////
   // Stimulus
   ///////////////////////////////
   initial begin
      void'($urandom(32'h2812_6687));
      cycles      = 0;
      rst_i       = 1'b1;
      cpu_en_i    = 1'b0;
      cpu_we_i    = 1'b0;
      cpu_addr_i  = '0;
      cpu_wdata_i = '0;
      for (int i = 0; i < 1024; i++) begin
         mem[i] = 32'hC0DE_0000 ^ (i * 32'h0001_0003);
      end
      for (int i = 0; i < 16; i++) begin
         preg[i] = 32'hBEEF_0000 | i;
      end
      repeat (16) @(posedge Clk);
      @(negedge Clk);
      rst_i = 1'b0;
      for (int n = 0; n < N_ENTRIES; n++) begin
         @(negedge Clk);
         cpu_en_i    = 1'b1;
         cpu_we_i    = STIM[n][64];
         cpu_addr_i  = STIM[n][63:32];
         cpu_wdata_i = STIM[n][31:0];
         do @(posedge Clk); while (cpu_stall_o);
         @(negedge Clk);
         cpu_en_i = 1'b0;
      end
      do @(posedge Clk); while (wr_busy);   // Let the last drain finish
      $display("checks done, %0d errors", errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
mem_sub_pkg.sv
data_cache.sv
linefill_buffer.sv
line_write_buffer.sv
mem_controller.sv
mem_subsystem.sv
mem_checker.sv
tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for the failure banner
rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module tb_mem_subsystem -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1 || exit 0
